// File: design/reduce_config.svh
`ifndef REDUCE_CONFIG_SVH
`define REDUCE_CONFIG_SVH

// number of reductions that can be open at the same time
// the stimulus never opens more indices than this, or the input stalls for good
`define RED_TABLE_SIZE 2

// width of a table slot number, shared by the table, the combiner and the top
`define RED_SLOT_BITS $clog2(`RED_TABLE_SIZE)

// cycles from aluValid to resValid in the combiner
`define RED_ALU_LATENCY 4

// packets the output queue can hold before emitReady drops
`define RED_OUT_DEPTH 2

`endif

// File: design/netPkg.sv
package netPkg;

  // node and rank numbers, eight nodes at most
  typedef logic [2:0] nodeIdT;

  // reduction index carried by every contribution
  typedef logic [3:0] indexT;

  // 64-bit network packet, msb first
  typedef struct packed {
    logic        valid;
    // set for a contribution to a reduction, clear for pass-through
    logic        reduction;
    nodeIdT      src;
    nodeIdT      dst;
    // carried untouched by this node
    logic [3:0]  pktType;
    logic [1:0]  algType;
    indexT       index;
    // number of children, so commsize+1 contributions per index
    logic [2:0]  commsize;
    nodeIdT      root;
    nodeIdT      rank;
    // raw op code, decoded by the combiner
    logic [4:0]  op;
    logic [31:0] payload;
  } packetT;

endpackage

// File: design/reducePkg.sv
package reducePkg;

  // reduction operations
  // codes outside this set combine as opSum
  typedef enum logic [4:0] {
    opSum     = 5'd0,
    opSumPair = 5'd1,
    opMax     = 5'd2,
    opMin     = 5'd3
  } opT;

  // one payload word read two ways
  // the op decides which view the combiner works on
  typedef union packed {
    // whole-word view for opSum, opMax and opMin
    logic signed [31:0] word;
    // lane view for opSumPair, lane 0 is the low half
    logic [1:0][15:0]   lane;
  } payloadT;

  // 67-bit word handed from decode to the table
  typedef struct packed {
    // contributions still to combine, 0 for pass-through and leaves
    logic [2:0]     children;
    netPkg::packetT pkt;
  } entryT;

endpackage

// File: design/packetIngress.sv
`timescale 1ns/1ps

module packetIngress (
  input  logic           clk,
  input  logic           rst,
  input  netPkg::packetT inPacket,
  input  logic           inReq,
  output logic           inAck,
  output netPkg::packetT pkt,
  output logic           pktValid,
  input  logic           pktReady
);

  // registered copy of the request line
  logic reqQ;

  // pktValid and inAck together form the receive state
  // both low is idle, pktValid is holding, inAck is waiting for req to drop
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      reqQ     <= 1'b0;
      pktValid <= 1'b0;
      inAck    <= 1'b0;
    end
    else
    begin
      reqQ <= inReq;
      if (pktValid)
      begin
        // ack only once decode has taken the packet
        if (pktReady)
        begin
          pktValid <= 1'b0;
          inAck    <= 1'b1;
        end
      end
      else if (inAck)
      begin
        // sender has dropped req, finish the handshake
        if (!reqQ)
          inAck <= 1'b0;
      end
      else if (reqQ)
        pktValid <= 1'b1;
    end
  end

  // sender holds inPacket while req is high, so the late sample is safe
  always_ff @(posedge clk)
  begin
    if (!pktValid && !inAck && reqQ)
      pkt <= inPacket;
  end

endmodule

// File: design/reduceInstr.sv
`timescale 1ns/1ps

module reduceInstr (
  input  logic             clk,
  input  logic             rst,
  input  netPkg::packetT   pkt,
  input  logic             pktValid,
  output logic             pktReady,
  output reducePkg::entryT entry,
  output logic             entryValid,
  input  logic             entryReady
);

  reducePkg::entryT nextEntry;

  // build the table word from the incoming packet
  always_comb
  begin
    nextEntry.pkt      = pkt;
    nextEntry.children = 3'd0;
    if (pkt.reduction)
    begin
      // the result heads for the root of the reduction
      nextEntry.pkt.dst  = pkt.root;
      nextEntry.children = pkt.commsize;
    end
  end

  // single register stage, refilled as soon as the table takes it
  assign pktReady = !entryValid || entryReady;

  always_ff @(posedge clk)
  begin
    if (rst)
      entryValid <= 1'b0;
    else if (pktReady)
      entryValid <= pktValid;
  end

  always_ff @(posedge clk)
  begin
    if (pktValid && pktReady)
      entry <= nextEntry;
  end

endmodule

// File: design/reduceTable.sv
`timescale 1ns/1ps
`include "reduce_config.svh"

module reduceTable (
  input  logic                       clk,
  input  logic                       rst,
  input  reducePkg::entryT           entry,
  input  logic                       entryValid,
  output logic                       entryReady,
  output logic                       aluValid,
  output reducePkg::opT              aluOp,
  output reducePkg::payloadT         aluA,
  output reducePkg::payloadT         aluB,
  output logic [`RED_SLOT_BITS-1:0]  aluSlot,
  input  logic                       resValid,
  input  logic [`RED_SLOT_BITS-1:0]  resSlot,
  input  reducePkg::payloadT         resPayload,
  output netPkg::packetT             emitPacket,
  output logic                       emitValid,
  input  logic                       emitReady
);

  localparam int N     = `RED_TABLE_SIZE;
  localparam int SlotW = `RED_SLOT_BITS;

  // open reductions, holding the first contribution and the running payload
  reducePkg::entryT store [N];
  // busy marks an open entry, inFlight a combine in the ALU
  // done marks a finished result waiting for the emit register
  logic [N-1:0]     busy;
  logic [N-1:0]     inFlight;
  logic [N-1:0]     done;

  logic [N-1:0]     hit;
  logic             anyHit;
  logic             anyFree;
  logic             anyDone;
  logic [SlotW-1:0] hitSlot;
  logic [SlotW-1:0] freeSlot;
  logic [SlotW-1:0] doneSlot;
  logic             emitFree;
  logic             retire;
  logic             toEmit;
  logic             toAlu;
  logic             toAlloc;
  logic             takeEntry;

  always_comb
  begin
    hit      = '0;
    hitSlot  = '0;
    freeSlot = '0;
    doneSlot = '0;
    anyFree  = 1'b0;
    anyDone  = 1'b0;
    // walk down so the lowest slot wins
    for (int i = N - 1; i >= 0; i--)
    begin
      if (busy[i] && store[i].pkt.index == entry.pkt.index)
      begin
        hit[i]  = 1'b1;
        hitSlot = SlotW'(i);
      end
      if (!busy[i])
      begin
        anyFree  = 1'b1;
        freeSlot = SlotW'(i);
      end
      if (done[i])
      begin
        anyDone  = 1'b1;
        doneSlot = SlotW'(i);
      end
    end
    anyHit   = |hit;
    emitFree = !emitValid || emitReady;
    // a finished result always gets the emit register first
    retire   = anyDone && emitFree;
    // pass-through and leaf packets go straight out
    toEmit   = !entry.pkt.reduction || (!anyHit && entry.children == 3'd0);
    toAlu    = entry.pkt.reduction && anyHit;
    toAlloc  = entry.pkt.reduction && !anyHit && entry.children != 3'd0;
    // same index waits while its combine is in flight or its result is unsent
    entryReady = (toEmit && emitFree && !anyDone)
               || (toAlu && !inFlight[hitSlot] && !done[hitSlot])
               || (toAlloc && anyFree);
    takeEntry  = entryValid && entryReady;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy      <= '0;
      inFlight  <= '0;
      done      <= '0;
      aluValid  <= 1'b0;
      emitValid <= 1'b0;
    end
    else
    begin
      aluValid <= takeEntry && toAlu;
      if (emitFree)
        emitValid <= retire || (takeEntry && toEmit);
      if (resValid)
      begin
        inFlight[resSlot] <= 1'b0;
        // last combine back, the result is complete
        if (store[resSlot].children == 3'd0)
          done[resSlot] <= 1'b1;
      end
      if (retire)
      begin
        busy[doneSlot] <= 1'b0;
        done[doneSlot] <= 1'b0;
      end
      if (takeEntry && toAlu)
        inFlight[hitSlot] <= 1'b1;
      if (takeEntry && toAlloc)
        busy[freeSlot] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (resValid)
      store[resSlot].pkt.payload <= resPayload;
    if (takeEntry && toAlloc)
      store[freeSlot] <= entry;
    if (takeEntry && toAlu)
    begin
      store[hitSlot].children <= store[hitSlot].children - 3'd1;
      // stored op comes from the first contribution
      aluOp   <= reducePkg::opT'(store[hitSlot].pkt.op);
      aluA    <= reducePkg::payloadT'(store[hitSlot].pkt.payload);
      aluB    <= reducePkg::payloadT'(entry.pkt.payload);
      aluSlot <= hitSlot;
    end
    if (retire)
      emitPacket <= store[doneSlot].pkt;
    else if (takeEntry && toEmit)
      emitPacket <= entry.pkt;
  end

endmodule

// File: design/reduceAlu.sv
`timescale 1ns/1ps
`include "reduce_config.svh"

module reduceAlu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      aluValid,
  input  reducePkg::opT             aluOp,
  input  reducePkg::payloadT        aluA,
  input  reducePkg::payloadT        aluB,
  input  logic [`RED_SLOT_BITS-1:0] aluSlot,
  output logic                      resValid,
  output logic [`RED_SLOT_BITS-1:0] resSlot,
  output reducePkg::payloadT        resPayload
);

  localparam int Lat = `RED_ALU_LATENCY;

  reducePkg::payloadT        result;
  reducePkg::payloadT        pipeData [Lat];
  logic [`RED_SLOT_BITS-1:0] pipeSlot [Lat];
  logic [Lat-1:0]            pipeValid;

  always_comb
  begin
    result = aluA;
    case (aluOp)
      reducePkg::opSumPair:
      begin
        // lanes wrap on their own, no carry across
        result.lane[0] = aluA.lane[0] + aluB.lane[0];
        result.lane[1] = aluA.lane[1] + aluB.lane[1];
      end
      // signed compares on the word view
      reducePkg::opMax:
        result.word = (aluA.word > aluB.word) ? aluA.word : aluB.word;
      reducePkg::opMin:
        result.word = (aluA.word < aluB.word) ? aluA.word : aluB.word;
      default:
        result.word = aluA.word + aluB.word;
    endcase
  end

  // valid bits track which stages hold a live combine
  always_ff @(posedge clk)
  begin
    if (rst)
      pipeValid <= '0;
    else
    begin
      pipeValid[0] <= aluValid;
      for (int s = 1; s < Lat; s++)
        pipeValid[s] <= pipeValid[s-1];
    end
  end

  always_ff @(posedge clk)
  begin
    pipeData[0] <= result;
    pipeSlot[0] <= aluSlot;
    for (int s = 1; s < Lat; s++)
    begin
      pipeData[s] <= pipeData[s-1];
      pipeSlot[s] <= pipeSlot[s-1];
    end
  end

  assign resValid   = pipeValid[Lat-1];
  assign resSlot    = pipeSlot[Lat-1];
  assign resPayload = pipeData[Lat-1];

endmodule

// File: design/packetEgress.sv
`timescale 1ns/1ps
`include "reduce_config.svh"

module packetEgress (
  input  logic           clk,
  input  logic           rst,
  input  netPkg::packetT emitPacket,
  input  logic           emitValid,
  output logic           emitReady,
  output netPkg::packetT outPacket,
  output logic           outReq,
  input  logic           outAck
);

  localparam int Depth = `RED_OUT_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  netPkg::packetT mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  // ack seen high, waiting for it to fall before the pop
  logic            ackSeen;
  logic            push;
  logic            pop;

  assign emitReady = count != CntW'(Depth);
  assign push      = emitValid && emitReady;
  assign pop       = ackSeen && !outAck;
  // head stays put until the pop, so the packet is stable under req
  assign outPacket = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      outReq  <= 1'b0;
      ackSeen <= 1'b0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
      // four-phase send
      if (outReq)
      begin
        if (outAck)
        begin
          outReq  <= 1'b0;
          ackSeen <= 1'b1;
        end
      end
      else if (ackSeen)
      begin
        if (!outAck)
          ackSeen <= 1'b0;
      end
      else if (count != '0)
        outReq <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= emitPacket;
  end

endmodule

// File: design/reduceNode.sv
`timescale 1ns/1ps
`include "reduce_config.svh"

module reduceNode (
  input  logic           clk,
  input  logic           rst,
  input  netPkg::packetT inPacket,
  input  logic           inReq,
  output logic           inAck,
  output netPkg::packetT outPacket,
  output logic           outReq,
  input  logic           outAck
);

  // ingress to decode
  netPkg::packetT            pkt;
  logic                      pktValid;
  logic                      pktReady;
  // decode to table
  reducePkg::entryT          entry;
  logic                      entryValid;
  logic                      entryReady;
  // table to combiner and back
  logic                      aluValid;
  reducePkg::opT             aluOp;
  reducePkg::payloadT        aluA;
  reducePkg::payloadT        aluB;
  logic [`RED_SLOT_BITS-1:0] aluSlot;
  logic                      resValid;
  logic [`RED_SLOT_BITS-1:0] resSlot;
  reducePkg::payloadT        resPayload;
  // table to egress
  netPkg::packetT            emitPacket;
  logic                      emitValid;
  logic                      emitReady;

  packetIngress ingress (
    .clk(clk), .rst(rst), .inPacket(inPacket), .inReq(inReq), .inAck(inAck),
    .pkt(pkt), .pktValid(pktValid), .pktReady(pktReady)
  );

  reduceInstr decode (
    .clk(clk), .rst(rst), .pkt(pkt), .pktValid(pktValid), .pktReady(pktReady),
    .entry(entry), .entryValid(entryValid), .entryReady(entryReady)
  );

  reduceTable table0 (
    .clk(clk), .rst(rst), .entry(entry), .entryValid(entryValid),
    .entryReady(entryReady), .aluValid(aluValid), .aluOp(aluOp), .aluA(aluA),
    .aluB(aluB), .aluSlot(aluSlot), .resValid(resValid), .resSlot(resSlot),
    .resPayload(resPayload), .emitPacket(emitPacket), .emitValid(emitValid),
    .emitReady(emitReady)
  );

  reduceAlu alu (
    .clk(clk), .rst(rst), .aluValid(aluValid), .aluOp(aluOp), .aluA(aluA),
    .aluB(aluB), .aluSlot(aluSlot), .resValid(resValid), .resSlot(resSlot),
    .resPayload(resPayload)
  );

  packetEgress egress (
    .clk(clk), .rst(rst), .emitPacket(emitPacket), .emitValid(emitValid),
    .emitReady(emitReady), .outPacket(outPacket), .outReq(outReq), .outAck(outAck)
  );

endmodule

// File: test/reduceNodeTb.sv
`timescale 1ns/1ps

module reduceNodeTb;

  logic           clk;
  logic           rst;
  netPkg::packetT inPacket;
  logic           inReq;
  logic           inAck;
  netPkg::packetT outPacket;
  logic           outReq;
  logic           outAck;

  // one entry per S or E line of the cases file
  bit             lineIsSend [$];
  netPkg::packetT lineWord [$];
  int             lineCount = 0;

  // expected outputs of the running test
  netPkg::packetT expPool [$];
  bit             expUsed [$];

  int             errors = 0;
  int             groupSeen = 0;
  int             totalSeen = 0;
  int             totalExp = 0;
  int             totalSent = 0;
  int             testNum = 0;
  int             cycles = 0;
  int             limit = 0;
  int             ackDelay;
  logic [7:0]     lfsr;

  reduceNode UUT (
    .clk(clk), .rst(rst), .inPacket(inPacket), .inReq(inReq), .inAck(inAck),
    .outPacket(outPacket), .outReq(outReq), .outAck(outAck)
  );

  always #4 clk = ~clk;

  // x^8 + x^6 + x^5 + x^4 + 1, shifting toward the msb
  function automatic logic [7:0] lfsrNext(input logic [7:0] s);
    lfsrNext = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // ack delay of 0 to 3 cycles, one lfsr step per bit
  task automatic drawDelay(output int d);
    d = 0;
    for (int b = 0; b < 2; b++)
    begin
      lfsr = lfsrNext(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic netPkg::packetT headerOnly(input netPkg::packetT p);
    netPkg::packetT h;
    h = p;
    h.payload = '0;
    return h;
  endfunction

  task automatic checkPacket(input string name, input netPkg::packetT exp,
                             input netPkg::packetT got);
    if (got !== exp)
    begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic checkPayload(input string name, input reducePkg::payloadT exp,
                              input reducePkg::payloadT got);
    if (got !== exp)
    begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // results are keyed by reduction bit, src and index, so order is free
  task automatic matchPacket(input netPkg::packetT got);
    int hit;
    hit = -1;
    for (int k = 0; k < expPool.size(); k++)
    begin
      if (hit < 0 && !expUsed[k] && expPool[k].reduction == got.reduction
          && expPool[k].src == got.src && expPool[k].index == got.index)
        hit = k;
    end
    if (hit < 0)
    begin
      $display("%0t unexpected output packet %h matches no expected packet", $time, got);
      errors++;
    end
    else
    begin
      expUsed[hit] = 1'b1;
      checkPacket("outPacket", headerOnly(expPool[hit]), headerOnly(got));
      checkPayload("outPacket.payload", reducePkg::payloadT'(expPool[hit].payload),
                   reducePkg::payloadT'(got.payload));
    end
    groupSeen++;
    totalSeen++;
  endtask

  // four-phase send, inputs change only on the rising edge
  task automatic sendPacket(input netPkg::packetT p);
    @(posedge clk);
    inPacket <= p;
    inReq    <= 1'b1;
    @(posedge clk);
    while (!inAck)
      @(posedge clk);
    inReq <= 1'b0;
    @(posedge clk);
    while (inAck)
      @(posedge clk);
  endtask

  task automatic readCases();
    int          fd;
    string       line;
    string       tag;
    logic [63:0] word;
    fd = $fopen("test/reduceCases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open test/reduceCases.txt for reading");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) != 0)
        begin
          lineCount++;
          // comment lines never carry an S or E tag
          if ($sscanf(line, "%s %h", tag, word) == 2 && (tag == "S" || tag == "E"))
          begin
            lineIsSend.push_back(tag == "S");
            lineWord.push_back(netPkg::packetT'(word));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // a test is a run of S lines followed by the E lines it produces
  task automatic runTests();
    int i;
    int first;
    int nSend;
    int errBefore;
    i = 0;
    while (i < lineWord.size())
    begin
      testNum++;
      errBefore = errors;
      expPool.delete();
      expUsed.delete();
      groupSeen = 0;
      nSend = 0;
      first = i;
      while (i < lineWord.size() && lineIsSend[i])
      begin
        nSend++;
        i++;
      end
      while (i < lineWord.size() && !lineIsSend[i])
      begin
        expPool.push_back(lineWord[i]);
        expUsed.push_back(1'b0);
        i++;
      end
      totalExp += expPool.size();
      totalSent += nSend;
      for (int k = first; k < first + nSend; k++)
        sendPacket(lineWord[k]);
      while (groupSeen < expPool.size())
        @(negedge clk);
      for (int k = 0; k < expPool.size(); k++)
      begin
        if (!expUsed[k])
        begin
          $display("expected packet %h was never received", expPool[k]);
          errors++;
        end
      end
      $display("test %0d: %0d sent, %0d expected, %0d seen, %s", testNum, nSend,
               expPool.size(), groupSeen, (errors == errBefore) ? "ok" : "mismatch");
    end
  endtask

  // receiver acks each output after a random delay
  initial
  begin
    forever
    begin
      @(posedge clk);
      if (!rst && outReq)
      begin
        drawDelay(ackDelay);
        repeat (ackDelay)
          @(posedge clk);
        matchPacket(outPacket);
        outAck <= 1'b1;
        while (outReq)
          @(posedge clk);
        outAck <= 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (limit > 0 && cycles >= limit)
    begin
      $display("timeout after %0d cycles in test %0d with %0d of %0d packets seen",
               cycles, testNum, groupSeen, expPool.size());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    inReq    = 1'b0;
    inPacket = '0;
    outAck   = 1'b0;
    lfsr     = 8'd36;
    readCases();
    limit = 40 * lineCount;
    repeat (2)
      @(posedge clk);
    rst <= 1'b0;
    runTests();
    // quiet window to catch stray or duplicate outputs
    repeat (32)
      @(posedge clk);
    if (totalSeen != totalExp)
    begin
      $display("received %0d output packets but the file expects %0d", totalSeen, totalExp);
      errors++;
    end
    $display("%0d tests, %0d packets sent, %0d received, %0d errors", testNum, totalSent,
             totalSeen, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: test/reduceCases.txt
# S <hex> sends a 64-bit packet, E <hex> is an expected output packet
# a run of S lines and the E lines after it form one test
S 9535C040DEADBEEF
S B1A8EC2712345678
S 819B000010000001
E 9535C040DEADBEEF
E B1A8EC2712345678
E 819B000010000001
S C7105B00FFFFFFF0
S D8790660CAFEF00D
S CF105B2000000020
S D7105B4080000000
S E7105B807FFFFFFF
E C3105B000000000F
E DE790660CAFEF00D
S D82C8D61FFFF0001
S C4015102FFFFFF9C
S F02C8DC10003FFFF
S D401514200000005
S FC0151E280000001
E DD2C8D6100020000
E C101510200000005
S C2F2970000000100
S EB46C8A37FFFFFFF
S A21280000BADF00D
S CAF2972000000200
S F346C8C380000000
S BFCC3BFF55AA55AA
S D2F2974000000300
E A21280000BADF00D
E E846C8A380000000
E BFCC3BFF55AA55AA
E C7F2970000000600

// File: verilog.f
+incdir+design
design/netPkg.sv
design/reducePkg.sv
design/packetIngress.sv
design/reduceInstr.sv
design/reduceTable.sv
design/reduceAlu.sv
design/packetEgress.sv
design/reduceNode.sv
test/reduceNodeTb.sv

// File: Makefile
# Verilator build and run of the reduction node testbench

TOP = reduceNodeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
